// ==== verilog.f ====
+incdir+dv
rtl/sd_emu_pkg.sv
rtl/sd_spi_phy.sv
rtl/sd_byte_counter.sv
rtl/sd_cmd_fsm.sv
rtl/sd_byte_ram.sv
rtl/sd_apb_regs.sv
rtl/sd_card_top.sv
dv/tb_sd_card.sv

// ==== Bender.yml ====
package:
  name: sd_card_emu

sources:
  - include_dirs:
      - dv
    files:
      - rtl/sd_emu_pkg.sv
      - rtl/sd_spi_phy.sv
      - rtl/sd_byte_counter.sv
      - rtl/sd_cmd_fsm.sv
      - rtl/sd_byte_ram.sv
      - rtl/sd_apb_regs.sv
      - rtl/sd_card_top.sv
      - dv/tb_sd_card.sv

// ==== dv/tb_sd_tasks.svh ====
`ifndef TB_SD_TASKS_SVH
`define TB_SD_TASKS_SVH

// galois form, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr(input logic [31:0] s);
	lfsr = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit
task automatic next_rand_byte(output logic [7:0] b);
	for (int i = 0; i < 8; i++) begin
		b[i] = lfsr_state[0];
		lfsr_state = lfsr(lfsr_state);
	end
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("Error: %s = %h, expected %h", name, got, exp);
		error_count++;
		$display("FAIL: see errors above");
		$fatal(1, "check failed");
	end
endtask

task automatic stop_run(input string what);
	$display("%s", what);
	error_count++;
	$display("FAIL: see errors above");
	$fatal(1, "run stopped");
endtask

// pready and prdata are looked at inside the low clock phase
task automatic apb_access(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
	output logic [31:0] rdata);
	int waits;
	logic ram_rd;
	waits = 0;
	@(negedge buffer_dout_strobe);
	paddr = addr;
	pwrite = wr;
	pwdata = wdata;
	psel = 1'b1;
	penable = 1'b0;
	@(negedge buffer_dout_strobe);
	penable = 1'b1;
	#10;
	while (!pready) begin
		@(negedge buffer_dout_strobe);
		#10;
		waits++;
	end
	rdata = prdata;
	apb_err = pslverr;
	// sector and id reads take one wait state, everything else none
	ram_rd = !wr && (addr < sd_emu_pkg::addr_id_base + 12'(4 * sd_emu_pkg::id_bytes));
	check("pready wait states", waits, ram_rd ? 32'd1 : 32'd0);
	@(negedge buffer_dout_strobe);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
	logic [31:0] unused;
	apb_access(addr, 1'b1, data, unused);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
	apb_access(addr, 1'b0, 32'h0, data);
endtask

// mode 0, sdo sampled just before the rising sck
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
	for (int i = 7; i >= 0; i--) begin
		@(negedge buffer_dout_strobe);
		sd_sdi = tx[i];
		repeat (4) @(negedge buffer_dout_strobe);
		rx[i] = sd_sdo;
		sd_sck = 1'b1;
		repeat (4) @(negedge buffer_dout_strobe);
		sd_sck = 1'b0;
	end
endtask

task automatic get_r1(output logic [7:0] r1);
	logic found;
	found = 1'b0;
	for (int i = 0; i < 8 && !found; i++) begin
		spi_byte(8'hff, r1);
		found = (r1 != 8'hff);
	end
	if (!found) stop_run("no R1 reply within 8 bytes");
endtask

task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg, output logic [7:0] r1);
	logic [7:0] unused;
	spi_byte({2'b01, idx}, unused);
	for (int i = 3; i >= 0; i--) begin
		spi_byte(arg[i*8 +: 8], unused);
	end
	// crc is not checked by the card
	spi_byte(8'h95, unused);
	get_r1(r1);
endtask

task automatic read_word(output logic [31:0] w);
	for (int i = 3; i >= 0; i--) begin
		spi_byte(8'hff, w[i*8 +: 8]);
	end
endtask

task automatic wait_token();
	logic [7:0] b;
	b = 8'hff;
	for (int i = 0; i < 8 && b != 8'hfe; i++) begin
		spi_byte(8'hff, b);
	end
	if (b != 8'hfe) stop_run("no data token within 8 bytes");
endtask

task automatic test_reset();
	logic [31:0] d;
	logic [7:0] r1;
	apb_read(sd_emu_pkg::addr_status, d);
	check("status", d, 32'h0);
	check("sd_sdo", sd_sdo, 1'b1);
	@(negedge buffer_dout_strobe);
	sd_cs = 1'b0;
	repeat (4) @(negedge buffer_dout_strobe);
	send_cmd(sd_emu_pkg::cmd_if_cond, 32'h1aa, r1);
	check("r1 cmd8 before cmd0", r1, 8'h04);
	send_cmd(sd_emu_pkg::cmd_go_idle, 32'h0, r1);
	check("r1 cmd0", r1, 8'h01);
endtask

task automatic test_config();
	logic [31:0] d;
	logic [7:0] r1;
	for (int i = 0; i < 32; i++) begin
		next_rand_byte(id_data[i]);
		apb_write(sd_emu_pkg::addr_id_base + 12'(4 * i), {24'h0, id_data[i]});
	end
	apb_write(sd_emu_pkg::addr_config, 32'h3);
	apb_read(sd_emu_pkg::addr_status, d);
	check("status", d, 32'h4);
	send_cmd(sd_emu_pkg::cmd_read_ocr, 32'h0, r1);
	check("r1 cmd58", r1, 8'h00);
	read_word(d);
	check("ocr bit30", d[30], 1'b1);
	// allow_sdhc cleared
	apb_write(sd_emu_pkg::addr_config, 32'h1);
	send_cmd(sd_emu_pkg::cmd_read_ocr, 32'h0, r1);
	check("r1 cmd58", r1, 8'h00);
	read_word(d);
	check("ocr bit30", d[30], 1'b0);
	apb_write(sd_emu_pkg::addr_config, 32'h3);
	send_cmd(sd_emu_pkg::cmd_if_cond, 32'h1aa, r1);
	check("r1 cmd8", r1, 8'h01);
	read_word(d);
	check("cmd8 echo", d, 32'h0000_01aa);
	send_cmd(sd_emu_pkg::cmd_set_blocklen, 32'd512, r1);
	check("r1 cmd16 512", r1, 8'h00);
	send_cmd(sd_emu_pkg::cmd_set_blocklen, 32'd1024, r1);
	check("r1 cmd16 1024", r1, 8'h40);
	send_cmd(sd_emu_pkg::cmd_app, 32'h0, r1);
	send_cmd(sd_emu_pkg::acmd_op_cond, 32'h4000_0000, r1);
	check("r1 acmd41", r1, 8'h00);
endtask

// csd sits at 16, cid at 0
task automatic test_id_read(input logic [5:0] idx, input int base);
	logic [7:0] r1;
	logic [7:0] b;
	send_cmd(idx, 32'h0, r1);
	check("r1 id read", r1, 8'h00);
	wait_token();
	for (int i = 0; i < 16; i++) begin
		spi_byte(8'hff, b);
		check("id byte", b, id_data[base + i]);
	end
endtask

task automatic test_sector_read();
	logic [31:0] d;
	logic [7:0] r1;
	logic [7:0] b;
	// byte addressing
	apb_write(sd_emu_pkg::addr_config, 32'h1);
	send_cmd(sd_emu_pkg::cmd_read_single, 32'h0000_3400, r1);
	check("r1 cmd17", r1, 8'h00);
	apb_read(sd_emu_pkg::addr_status, d);
	check("status", d, 32'h5);
	apb_read(sd_emu_pkg::addr_lba, d);
	check("lba", d, 32'h1a);
	for (int i = 0; i < 512; i++) begin
		next_rand_byte(sec_data[i]);
		apb_write(sd_emu_pkg::addr_sector_base + 12'(4 * i), {24'h0, sec_data[i]});
	end
	apb_write(sd_emu_pkg::addr_ack, 32'h1);
	apb_read(sd_emu_pkg::addr_status, d);
	check("status", d, 32'h4);
	wait_token();
	for (int i = 0; i < 512; i++) begin
		spi_byte(8'hff, b);
		check("read data byte", b, sec_data[i]);
	end
endtask

task automatic test_sector_write();
	logic [31:0] d;
	logic [7:0] r1;
	logic [7:0] b;
	apb_write(sd_emu_pkg::addr_config, 32'h3);
	for (int i = 0; i < 512; i++) begin
		next_rand_byte(sec_data[i]);
	end
	send_cmd(sd_emu_pkg::cmd_write_block, 32'h0000_0777, r1);
	check("r1 cmd24", r1, 8'h00);
	spi_byte(8'hfe, b);
	for (int i = 0; i < 512; i++) begin
		spi_byte(sec_data[i], b);
	end
	spi_byte(8'h12, b);
	spi_byte(8'h34, b);
	spi_byte(8'hff, b);
	check("data response", b, 8'h05);
	spi_byte(8'hff, b);
	check("busy byte", b, 8'h00);
	apb_read(sd_emu_pkg::addr_status, d);
	check("status", d, 32'h6);
	apb_read(sd_emu_pkg::addr_lba, d);
	check("lba", d, 32'h777);
	for (int i = 0; i < 512; i++) begin
		apb_read(sd_emu_pkg::addr_sector_base + 12'(4 * i), d);
		check("sector byte", d, {24'h0, sec_data[i]});
	end
	apb_write(sd_emu_pkg::addr_ack, 32'h1);
	// one busy byte may already be queued
	b = 8'h00;
	for (int i = 0; i < 4 && b != 8'hff; i++) begin
		spi_byte(8'hff, b);
	end
	if (b != 8'hff) stop_run("busy did not end after the write ack");
	spi_byte(8'hff, b);
	check("idle byte", b, 8'hff);
endtask

task automatic test_unmapped();
	logic [31:0] d;
	apb_read(12'ha00, d);
	check("pslverr", apb_err, 1'b1);
endtask

`endif

// ==== dv/tb_sd_card.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sd_card;

	localparam int clk_half = 50;
	// spi bytes over all tests, about 80 clocks each
	localparam int test_bytes = 1400;
	// apb accesses take a few clocks each
	localparam int apb_clocks = 6000;
	localparam int cycle_limit = test_bytes * 80 + apb_clocks + 10000;

	logic buffer_dout_strobe;
	logic io_ack;
	logic [11:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic sd_cs;
	logic sd_sck;
	logic sd_sdi;
	logic sd_sdo;

	int cycles;
	int error_count;
	logic apb_err;
	logic [31:0] lfsr_state;
	// expected contents of the id store and the sector buffer
	logic [7:0] id_data [32];
	logic [7:0] sec_data [512];

	sd_card_top dut0 (.buffer_dout_strobe, .io_ack, .paddr, .psel, .penable, .pwrite,
		.pwdata, .prdata, .pready, .pslverr, .sd_cs, .sd_sck, .sd_sdi, .sd_sdo);

	always #clk_half buffer_dout_strobe = ~buffer_dout_strobe;

	// run limit
	always @(posedge buffer_dout_strobe) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	initial begin
		buffer_dout_strobe = 1'b0;
		io_ack = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		sd_cs = 1'b1;
		sd_sck = 1'b0;
		sd_sdi = 1'b1;
		cycles = 0;
		error_count = 0;
		apb_err = 1'b0;
		lfsr_state = 32'h755dec13;
		repeat (2) @(posedge buffer_dout_strobe);
		@(negedge buffer_dout_strobe);
		io_ack = 1'b0;
		test_reset();
		test_config();
		test_id_read(sd_emu_pkg::cmd_send_csd, 16);
		test_id_read(sd_emu_pkg::cmd_send_cid, 0);
		test_sector_read();
		test_sector_write();
		test_unmapped();
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	`include "tb_sd_tasks.svh"

endmodule

`default_nettype wire

// ==== rtl/sd_card_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_card_top (
	input wire logic buffer_dout_strobe,
	input wire logic io_ack,
	input wire logic [sd_emu_pkg::apb_addr_w-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire logic sd_cs,
	input wire logic sd_sck,
	input wire logic sd_sdi,
	output logic sd_sdo
);

	logic [7:0] rx_byte;
	logic [7:0] tx_byte;
	logic byte_done;
	logic cs_active;
	logic cnt_load;
	logic [sd_emu_pkg::cnt_w-1:0] cnt_value;
	logic cnt_zero;
	logic ack_pulse;
	logic sdhc;
	sd_emu_pkg::sd_io_req_t req;
	// port a from the spi side, port b from apb
	sd_emu_pkg::ram_port_t sec_spi;
	sd_emu_pkg::ram_port_t id_spi;
	sd_emu_pkg::ram_port_t sec_apb;
	sd_emu_pkg::ram_port_t id_apb;
	logic [7:0] sec_rdata_a;
	logic [7:0] sec_rdata_b;
	logic [7:0] id_rdata_a;
	logic [7:0] id_rdata_b;

	sd_spi_phy phy0 (.buffer_dout_strobe, .io_ack, .sd_cs, .sd_sck, .sd_sdi, .tx_byte,
		.sd_sdo, .rx_byte, .byte_done, .cs_active);

	sd_byte_counter counter0 (.buffer_dout_strobe, .io_ack, .cnt_load, .cnt_value,
		.byte_done, .cnt_zero);

	sd_cmd_fsm fsm0 (.buffer_dout_strobe, .io_ack, .rx_byte, .byte_done, .cs_active,
		.cnt_zero, .ack_pulse, .sdhc, .sec_rdata(sec_rdata_a), .id_rdata(id_rdata_a),
		.tx_byte, .cnt_load, .cnt_value, .req, .sec_spi, .id_spi);

	sd_byte_ram #(.depth(sd_emu_pkg::sector_bytes)) sector_ram (.buffer_dout_strobe,
		.port_a(sec_spi), .port_b(sec_apb), .rdata_a(sec_rdata_a), .rdata_b(sec_rdata_b));

	sd_byte_ram #(.depth(sd_emu_pkg::id_bytes)) id_ram (.buffer_dout_strobe,
		.port_a(id_spi), .port_b(id_apb), .rdata_a(id_rdata_a), .rdata_b(id_rdata_b));

	sd_apb_regs regs0 (.buffer_dout_strobe, .io_ack, .paddr, .psel, .penable, .pwrite,
		.pwdata, .req, .sec_rdata_b, .id_rdata_b, .prdata, .pready, .pslverr,
		.sec_apb, .id_apb, .ack_pulse, .sdhc);

endmodule

`default_nettype wire

// ==== rtl/sd_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_apb_regs (
	input wire logic buffer_dout_strobe,
	input wire logic io_ack,
	input wire logic [sd_emu_pkg::apb_addr_w-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [31:0] pwdata,
	input wire sd_emu_pkg::sd_io_req_t req,
	input wire logic [7:0] sec_rdata_b,
	input wire logic [7:0] id_rdata_b,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output sd_emu_pkg::ram_port_t sec_apb,
	output sd_emu_pkg::ram_port_t id_apb,
	output logic ack_pulse,
	output logic sdhc
);

	logic access;
	logic wr_access;
	logic ram_rd;
	logic wait_done;
	logic is_sec;
	logic is_id;
	logic is_status;
	logic is_lba;
	logic is_config;
	logic is_ack;
	// bit0 host_sdhc, bit1 allow_sdhc
	logic [1:0] config_q;
	logic conf_written;
	logic [2:0] status_q;
	logic [31:0] lba_q;

	assign access = psel && penable;
	assign wr_access = access && pwrite;

	// address decode
	assign is_sec = (paddr < sd_emu_pkg::addr_id_base);
	assign is_id = (paddr[11:7] == sd_emu_pkg::addr_id_base[11:7]);
	assign is_status = (paddr == sd_emu_pkg::addr_status);
	assign is_lba = (paddr == sd_emu_pkg::addr_lba);
	assign is_config = (paddr == sd_emu_pkg::addr_config);
	assign is_ack = (paddr == sd_emu_pkg::addr_ack);

	// ram reads hold pready low for the first access cycle
	assign ram_rd = access && !pwrite && (is_sec || is_id);
	assign pready = !ram_rd || wait_done;
	assign pslverr = access &&
		!(is_sec || is_id || is_status || is_lba || is_config || is_ack);

	assign sec_apb = '{we: wr_access && is_sec, addr: {1'b0, paddr[10:2]},
		wdata: pwdata[7:0]};
	assign id_apb = '{we: wr_access && is_id, addr: {5'b0, paddr[6:2]},
		wdata: pwdata[7:0]};

	assign sdhc = &config_q;

	always_comb begin
		prdata = '0;
		if (is_sec) begin
			prdata = {24'h0, sec_rdata_b};
		end else if (is_id) begin
			prdata = {24'h0, id_rdata_b};
		end else if (is_status) begin
			prdata = {29'h0, status_q};
		end else if (is_lba) begin
			prdata = lba_q;
		end else if (is_config) begin
			prdata = {30'h0, config_q};
		end
	end

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			wait_done <= 1'b0;
			ack_pulse <= 1'b0;
			config_q <= 2'b00;
			conf_written <= 1'b0;
			status_q <= 3'b000;
		end else begin
			wait_done <= ram_rd && !wait_done;
			ack_pulse <= wr_access && is_ack && pwdata[0];
			if (wr_access && is_config) begin
				config_q <= pwdata[1:0];
				conf_written <= 1'b1;
			end
			// pending request bits follow the fsm
			status_q <= {conf_written, req.wr, req.rd};
		end
	end

	// sector number for the io controller, byte address without sdhc
	always_ff @(posedge buffer_dout_strobe) begin
		lba_q <= sdhc ? req.arg : {9'h0, req.arg[31:9]};
	end

endmodule

`default_nettype wire

// ==== rtl/sd_byte_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_byte_ram #(
	parameter int depth = 512
) (
	input wire logic buffer_dout_strobe,
	input wire sd_emu_pkg::ram_port_t port_a,
	input wire sd_emu_pkg::ram_port_t port_b,
	output logic [7:0] rdata_a,
	output logic [7:0] rdata_b
);

	logic [7:0] mem [depth];

	// both ports in one process, port b wins a same-address write
	always_ff @(posedge buffer_dout_strobe) begin
		if (port_a.we) begin
			mem[port_a.addr[$clog2(depth)-1:0]] <= port_a.wdata;
		end
		if (port_b.we) begin
			mem[port_b.addr[$clog2(depth)-1:0]] <= port_b.wdata;
		end
		// registered reads, old data on a collision
		rdata_a <= mem[port_a.addr[$clog2(depth)-1:0]];
		rdata_b <= mem[port_b.addr[$clog2(depth)-1:0]];
	end

endmodule

`default_nettype wire

// ==== rtl/sd_cmd_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_fsm (
	input wire logic buffer_dout_strobe,
	input wire logic io_ack,
	input wire logic [7:0] rx_byte,
	input wire logic byte_done,
	input wire logic cs_active,
	input wire logic cnt_zero,
	input wire logic ack_pulse,
	input wire logic sdhc,
	input wire logic [7:0] sec_rdata,
	input wire logic [7:0] id_rdata,
	output logic [7:0] tx_byte,
	output logic cnt_load,
	output logic [sd_emu_pkg::cnt_w-1:0] cnt_value,
	output sd_emu_pkg::sd_io_req_t req,
	output sd_emu_pkg::ram_port_t sec_spi,
	output sd_emu_pkg::ram_port_t id_spi
);

	// a state names what goes out in the byte after the current one
	typedef enum logic [3:0] {
		st_idle, st_gap, st_r1, st_extra, st_wait_io, st_token, st_data,
		st_rx_token, st_rx_data, st_crc, st_resp, st_busy
	} state_t;

	state_t state;
	state_t after_r1;
	state_t dec_next;
	sd_emu_pkg::sd_cmd_t cmd_q;
	logic [2:0] frame_cnt;
	logic frame_end;
	logic card_reset;
	logic app_cmd;
	logic use_sector;
	logic [7:0] r1_q;
	logic [7:0] dec_r1;
	logic [31:0] extra_q;
	logic [31:0] dec_extra;
	logic [sd_emu_pkg::ram_addr_w-1:0] ptr;

	assign frame_end = byte_done && (state == st_idle) &&
		(frame_cnt == 3'(sd_emu_pkg::cmd_frame_bytes - 1));
	assign use_sector = (cmd_q.index == sd_emu_pkg::cmd_read_single);

	// decode of the completed frame, crc byte is in flight
	always_comb begin
		dec_next = st_idle;
		dec_r1 = sd_emu_pkg::r1_illegal;
		dec_extra = '0;
		if (cmd_q.index == sd_emu_pkg::cmd_go_idle) begin
			dec_r1 = sd_emu_pkg::r1_idle;
		end else if (card_reset) begin
			case (cmd_q.index)
				sd_emu_pkg::cmd_op_cond: dec_r1 = sd_emu_pkg::r1_ok;
				sd_emu_pkg::cmd_if_cond: begin
					// voltage accepted, check pattern echoed
					dec_r1 = sd_emu_pkg::r1_idle;
					dec_extra = 32'h0000_01aa;
					dec_next = st_extra;
				end
				sd_emu_pkg::cmd_send_csd, sd_emu_pkg::cmd_send_cid: begin
					dec_r1 = sd_emu_pkg::r1_ok;
					dec_next = st_token;
				end
				sd_emu_pkg::cmd_set_blocklen: begin
					dec_r1 = (cmd_q.arg == 32'(sd_emu_pkg::sector_bytes)) ?
						sd_emu_pkg::r1_ok : sd_emu_pkg::r1_param;
				end
				sd_emu_pkg::cmd_read_single: begin
					dec_r1 = sd_emu_pkg::r1_ok;
					dec_next = st_wait_io;
				end
				sd_emu_pkg::cmd_write_block: begin
					dec_r1 = sd_emu_pkg::r1_ok;
					dec_next = st_rx_token;
				end
				sd_emu_pkg::cmd_app: dec_r1 = sd_emu_pkg::r1_idle;
				sd_emu_pkg::acmd_op_cond: begin
					if (app_cmd) begin
						dec_r1 = sd_emu_pkg::r1_ok;
					end
				end
				sd_emu_pkg::cmd_read_ocr: begin
					// ocr bit 30 flags a high capacity card
					dec_r1 = sd_emu_pkg::r1_ok;
					dec_extra = {1'b0, sdhc, 30'h0};
					dec_next = st_extra;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			state <= st_idle;
			after_r1 <= st_idle;
			frame_cnt <= 3'd0;
			card_reset <= 1'b0;
			app_cmd <= 1'b0;
			req <= '0;
		end else begin
			if (ack_pulse) begin
				req.rd <= 1'b0;
				req.wr <= 1'b0;
			end
			if (byte_done) begin
				case (state)
					st_idle: begin
						// frame starts with 01xxxxxx
						if (frame_end) begin
							frame_cnt <= 3'd0;
							state <= st_gap;
							after_r1 <= dec_next;
							card_reset <= card_reset ||
								(cmd_q.index == sd_emu_pkg::cmd_go_idle);
							app_cmd <= card_reset && (cmd_q.index == sd_emu_pkg::cmd_app);
						end else if (frame_cnt != 3'd0 || rx_byte[7:6] == 2'b01) begin
							frame_cnt <= frame_cnt + 3'd1;
						end
					end
					st_gap: if (cnt_zero) state <= st_r1;
					st_r1: begin
						state <= after_r1;
						// sector read goes out to the io controller
						if (after_r1 == st_wait_io) begin
							req <= '{rd: 1'b1, wr: 1'b0, arg: cmd_q.arg};
						end
					end
					st_extra, st_data: if (cnt_zero) state <= st_idle;
					st_wait_io: if (!req.rd) state <= st_token;
					st_token: state <= st_data;
					st_rx_token: begin
						if (rx_byte == sd_emu_pkg::data_token) state <= st_rx_data;
					end
					st_rx_data: if (cnt_zero) state <= st_crc;
					// second crc byte is being received
					st_crc: state <= st_resp;
					st_resp: begin
						state <= st_busy;
						req <= '{rd: 1'b0, wr: 1'b1, arg: cmd_q.arg};
					end
					st_busy: if (!req.wr) state <= st_idle;
					default: state <= st_idle;
				endcase
			end
			if (!cs_active && state == st_idle) begin
				frame_cnt <= 3'd0;
			end
		end
	end

	// frame payload, reply bytes and buffer pointer
	always_ff @(posedge buffer_dout_strobe) begin
		if (byte_done) begin
			if (state == st_idle && frame_cnt == 3'd0) begin
				cmd_q.index <= rx_byte[5:0];
			end else if (state == st_idle && frame_cnt < 3'd5) begin
				cmd_q.arg <= {cmd_q.arg[23:0], rx_byte};
			end
			if (frame_end) begin
				r1_q <= dec_r1;
				extra_q <= dec_extra;
			end
			if (state == st_extra) begin
				extra_q <= {extra_q[23:0], 8'hff};
			end
			// csd lives in the upper half of the id store
			if (state == st_r1) begin
				ptr <= (cmd_q.index == sd_emu_pkg::cmd_send_csd) ?
					10'(sd_emu_pkg::id_bytes / 2) : '0;
			end
			if (state == st_data || state == st_rx_data) begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	// counter loads, all values are byte count minus one
	always_comb begin
		cnt_load = 1'b0;
		cnt_value = '0;
		if (frame_end) begin
			cnt_load = 1'b1;
			cnt_value = 10'(sd_emu_pkg::ncr_bytes - 2);
		end else if (byte_done && state == st_r1 && after_r1 == st_extra) begin
			// four bytes of ocr or if_cond echo
			cnt_load = 1'b1;
			cnt_value = 10'd3;
		end else if (byte_done && state == st_token) begin
			cnt_load = 1'b1;
			cnt_value = use_sector ? 10'(sd_emu_pkg::sector_bytes - 1) :
				10'(sd_emu_pkg::id_bytes / 2 - 1);
		end else if (byte_done && state == st_rx_token &&
			rx_byte == sd_emu_pkg::data_token) begin
			cnt_load = 1'b1;
			cnt_value = 10'(sd_emu_pkg::sector_bytes - 1);
		end
	end

	always_comb begin
		case (state)
			st_r1: tx_byte = r1_q;
			st_extra: tx_byte = extra_q[31:24];
			st_token: tx_byte = sd_emu_pkg::data_token;
			st_data: tx_byte = use_sector ? sec_rdata : id_rdata;
			st_resp: tx_byte = sd_emu_pkg::data_resp_ok;
			// busy is signalled with zero bytes until the ack
			st_busy: tx_byte = req.wr ? 8'h00 : 8'hff;
			default: tx_byte = 8'hff;
		endcase
	end

	assign sec_spi = '{we: byte_done && state == st_rx_data, addr: ptr, wdata: rx_byte};
	// id store is read only from the spi side
	assign id_spi = '{we: 1'b0, addr: ptr, wdata: 8'h00};

	assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		!(req.rd && req.wr));
	// buffer is never overwritten while the io controller owns it
	assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		sec_spi.we |-> !req.rd && !req.wr);

endmodule

`default_nettype wire

// ==== rtl/sd_byte_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_byte_counter (
	input wire logic buffer_dout_strobe,
	input wire logic io_ack,
	input wire logic cnt_load,
	input wire logic [sd_emu_pkg::cnt_w-1:0] cnt_value,
	input wire logic byte_done,
	output logic cnt_zero
);

	logic [sd_emu_pkg::cnt_w-1:0] count;

	// load wins over a byte boundary in the same cycle
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			count <= '0;
		end else if (cnt_load) begin
			count <= cnt_value;
		end else if (byte_done && !cnt_zero) begin
			count <= count - 1'b1;
		end
	end

	assign cnt_zero = (count == '0);

	// no wrap, zero holds until the fsm reloads
	assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		cnt_zero && !cnt_load |=> cnt_zero);

endmodule

`default_nettype wire

// ==== rtl/sd_spi_phy.sv ====
`timescale 1ns/100ps
`default_nettype none

module sd_spi_phy (
	input wire logic buffer_dout_strobe,
	input wire logic io_ack,
	input wire logic sd_cs,
	input wire logic sd_sck,
	input wire logic sd_sdi,
	input wire logic [7:0] tx_byte,
	output logic sd_sdo,
	output logic [7:0] rx_byte,
	output logic byte_done,
	output logic cs_active
);

	// two sync stages, sck has a third one for the edge detect
	logic [1:0] cs_q;
	logic [2:0] sck_q;
	logic [1:0] sdi_q;
	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic [7:0] tx_shift;
	logic sck_rise;
	logic sck_fall;

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign sck_fall = ~sck_q[1] & sck_q[2];
	// cs is active low on the pin
	assign cs_active = ~cs_q[1];

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			cs_q <= 2'b11;
			sck_q <= 3'b000;
			sdi_q <= 2'b11;
		end else begin
			cs_q <= {cs_q[0], sd_cs};
			sck_q <= {sck_q[1:0], sd_sck};
			sdi_q <= {sdi_q[0], sd_sdi};
		end
	end

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			bit_cnt <= 3'd0;
			byte_done <= 1'b0;
			tx_shift <= 8'hff;
			sd_sdo <= 1'b1;
		end else begin
			byte_done <= 1'b0;
			if (!cs_active) begin
				// deselected, realign and idle the line high
				bit_cnt <= 3'd0;
				tx_shift <= 8'hff;
				sd_sdo <= 1'b1;
			end else begin
				if (sck_rise) begin
					bit_cnt <= bit_cnt + 3'd1;
					byte_done <= (bit_cnt == 3'd7);
				end
				// next bit goes out after the falling edge, msb first
				if (sck_fall) begin
					sd_sdo <= tx_shift[7];
					tx_shift <= {tx_shift[6:0], 1'b1};
				end
				// next byte from the fsm, its msb leaves on the following fall
				if (byte_done) begin
					tx_shift <= tx_byte;
				end
			end
		end
	end

	// receive shifter, sdi sampled with the same delay as sck
	always_ff @(posedge buffer_dout_strobe) begin
		if (sck_rise && cs_active) begin
			rx_shift <= {rx_shift[5:0], sdi_q[1]};
			if (bit_cnt == 3'd7) begin
				rx_byte <= {rx_shift, sdi_q[1]};
			end
		end
	end

	// the fsm never sees a byte boundary while the card is deselected
	assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		byte_done |-> cs_active);

endmodule

`default_nettype wire

// ==== rtl/sd_emu_pkg.sv ====
`default_nettype none

package sd_emu_pkg;

	// sizes
	localparam int unsigned sector_bytes = 512;
	// cid in the lower half, csd in the upper half
	localparam int unsigned id_bytes = 32;
	// 0xff bytes between the last command byte and r1
	localparam int unsigned ncr_bytes = 2;
	localparam int unsigned cmd_frame_bytes = 6;
	localparam int unsigned ram_addr_w = 10;
	localparam int unsigned cnt_w = 10;
	localparam int unsigned apb_addr_w = 12;

	// tokens and r1 codes
	localparam logic [7:0] data_token = 8'hfe;
	localparam logic [7:0] data_resp_ok = 8'h05;
	localparam logic [7:0] r1_idle = 8'h01;
	localparam logic [7:0] r1_ok = 8'h00;
	localparam logic [7:0] r1_illegal = 8'h04;
	localparam logic [7:0] r1_param = 8'h40;

	// command indices
	localparam logic [5:0] cmd_go_idle = 6'd0;
	localparam logic [5:0] cmd_op_cond = 6'd1;
	localparam logic [5:0] cmd_if_cond = 6'd8;
	localparam logic [5:0] cmd_send_csd = 6'd9;
	localparam logic [5:0] cmd_send_cid = 6'd10;
	localparam logic [5:0] cmd_set_blocklen = 6'd16;
	localparam logic [5:0] cmd_read_single = 6'd17;
	localparam logic [5:0] cmd_write_block = 6'd24;
	localparam logic [5:0] cmd_app = 6'd55;
	localparam logic [5:0] acmd_op_cond = 6'd41;
	localparam logic [5:0] cmd_read_ocr = 6'd58;

	// apb map, byte buffers sit on word offsets
	localparam logic [11:0] addr_sector_base = 12'h000;
	localparam logic [11:0] addr_id_base = 12'h800;
	localparam logic [11:0] addr_status = 12'h900;
	localparam logic [11:0] addr_lba = 12'h904;
	localparam logic [11:0] addr_config = 12'h908;
	localparam logic [11:0] addr_ack = 12'h90c;

	typedef struct packed {
		logic [5:0] index;
		logic [31:0] arg;
	} sd_cmd_t;

	typedef struct packed {
		logic rd;
		logic wr;
		logic [31:0] arg;
	} sd_io_req_t;

	typedef struct packed {
		logic we;
		logic [ram_addr_w-1:0] addr;
		logic [7:0] wdata;
	} ram_port_t;

endpackage

`default_nettype wire
